// File: daq_cfg_regs.sv
// Register decoder of the configuration bus
// Every access is acknowledged in the next cycle, write wins over read
// Writes return an echo of the written fields, not the stored value
// Error flag and table updates are driven combinationally from the request
module daq_cfg_regs #(
    parameter int NUM_SUBSAMPLES       = 32,
    parameter bit DEFAULT_SAMPLE_EXTRA = 1'b0
) (
    input  logic                         clock,
    input  logic                         reset,
    input  daq_pkg::cfg_req_t            cfg_req_i,
    input  daq_pkg::daq_status_t         status_i,
    input  logic [4:0]                   err_flags_i,
    input  logic [daq_pkg::IDX_W-1:0]    ss_chip_i,
    input  logic [daq_pkg::IDX_W-1:0]    ss_chan_i,
    output daq_pkg::cfg_rsp_t            cfg_rsp_o,
    output daq_pkg::daq_ctrl_t           ctrl_o,
    output daq_pkg::chip_cmd_t           cmd_o,
    output daq_pkg::err_ctrl_t           err_ctrl_o,
    output daq_pkg::ss_wr_t              ss_wr_o,
    output logic [daq_pkg::IDX_W-1:0]    ss_rd_index_o
);

    import daq_pkg::*;

    cfg_addr_e             addr;
    logic                  access;
    logic                  is_write;
    logic                  ss_hit;
    logic                  cfg_err;
    logic [IDX_W-1:0]      ss_index;
    logic [CFG_DATA_W-1:0] wdata;
    logic [CFG_DATA_W-1:0] rdata_d;
    logic [CFG_DATA_W-1:0] rdata_q;
    logic                  sack_q;
    daq_ctrl_t             ctrl_q;
    chip_cmd_t             cmd_q;

    assign addr     = cfg_addr_e'(cfg_req_i.addr);
    assign wdata    = cfg_req_i.wdata;
    assign access   = cfg_req_i.read_en | cfg_req_i.write_en;
    assign is_write = cfg_req_i.write_en;

    // Sub-sample window starts at SUBSAMPLE_BASE
    assign ss_hit   = (cfg_req_i.addr >= SUBSAMPLE_BASE) &&
                      (cfg_req_i.addr < SUBSAMPLE_BASE + NUM_SUBSAMPLES);
    assign ss_index = IDX_W'(cfg_req_i.addr - SUBSAMPLE_BASE);

    always_comb begin
        cfg_err = 1'b0;
        rdata_d = '0;
        case (addr)
            REG_ERRORS: begin
                rdata_d = is_write ? {27'd0, wdata[4:0]} : {27'd0, err_flags_i};
            end
            REG_ACQUIRE: begin
                rdata_d = is_write ? {23'd0, wdata[8], 7'd0, wdata[0]}
                                   : {23'd0, ctrl_q.is_master, 7'd0, ctrl_q.acquire_en};
            end
            REG_DESIRED_BSN: begin
                rdata_d = is_write ? wdata : ctrl_q.desired_bsn;
            end
            REG_BSN: begin
                cfg_err = is_write;
                rdata_d = status_i.board_sample_index;
            end
            REG_ALIVE: begin
                cfg_err = is_write;
                rdata_d = status_i.chips_alive;
            end
            REG_CMD: begin
                rdata_d = is_write ? {7'd0, wdata[24:0]}
                                   : {7'd0, cmd_q.write_en, cmd_q.chip, cmd_q.command};
            end
            REG_UDP_COUNT: begin
                cfg_err = is_write;
                rdata_d = {19'd0, status_i.udp_count};
            end
            REG_UDP_FIFO: begin
                rdata_d = is_write ? {31'd0, wdata[0]} : {31'd0, ctrl_q.udp_fifo_reset};
            end
            REG_UDP_EN: begin
                rdata_d = is_write ? {31'd0, wdata[0]} : {31'd0, ctrl_q.udp_en};
            end
            REG_UDP_MODE: begin
                rdata_d = is_write ? {31'd0, wdata[0]} : {31'd0, ctrl_q.udp_full_mode};
            end
            REG_SATA_EN: begin
                rdata_d = is_write ? {30'd0, wdata[1:0]}
                                   : {30'd0, ctrl_q.sata_align_start_en, ctrl_q.sata_en};
            end
            REG_SATA_COUNT: begin
                cfg_err = is_write;
                rdata_d = {17'd0, status_i.sata_count};
            end
            REG_SATA_FIFO: begin
                rdata_d = is_write ? {31'd0, wdata[0]} : {31'd0, ctrl_q.sata_fifo_reset};
            end
            REG_SAMPLE_EXTRA: begin
                rdata_d = is_write ? {31'd0, wdata[0]} : {31'd0, ctrl_q.sample_extra_en};
            end
            default: begin
                if (ss_hit) begin
                    rdata_d = is_write ? {19'd0, wdata[12:8], 3'd0, wdata[4:0]}
                                       : {19'd0, ss_chip_i, 3'd0, ss_chan_i};
                end else begin
                    cfg_err = 1'b1;                   // Unmapped address reads 0
                end
            end
        endcase
    end

    assign err_ctrl_o.load    = access && is_write && (addr == REG_ERRORS);
    assign err_ctrl_o.value   = wdata[4:0];
    assign err_ctrl_o.set_cfg = access && cfg_err;
    assign err_ctrl_o.hold    = access;

    assign ss_wr_o.en    = is_write && ss_hit;
    assign ss_wr_o.index = ss_index;
    assign ss_wr_o.chip  = wdata[12:8];
    assign ss_wr_o.chan  = wdata[4:0];
    assign ss_rd_index_o = ss_index;

    always_ff @(posedge clock) begin
        if (reset) begin
            sack_q                 <= 1'b0;
            ctrl_q                 <= '0;
            ctrl_q.sample_extra_en <= DEFAULT_SAMPLE_EXTRA;
            cmd_q                  <= '0;
        end else begin
            sack_q <= access;
            if (!access) begin
                ctrl_q.reset_bsi <= 1'b0;             // Pulse ends on first idle cycle
            end
            if (access && is_write) begin
                case (addr)
                    REG_ACQUIRE: begin
                        ctrl_q.acquire_en <= wdata[0];
                        ctrl_q.is_master  <= wdata[8];
                    end
                    REG_DESIRED_BSN: begin
                        ctrl_q.desired_bsn <= wdata;
                        ctrl_q.reset_bsi   <= 1'b1;
                    end
                    REG_CMD: begin
                        cmd_q.write_en <= wdata[24];
                        cmd_q.chip     <= wdata[23:16];
                        cmd_q.command  <= wdata[15:0];
                    end
                    REG_UDP_FIFO:     ctrl_q.udp_fifo_reset  <= wdata[0];
                    REG_UDP_EN:       ctrl_q.udp_en          <= wdata[0];
                    REG_UDP_MODE:     ctrl_q.udp_full_mode   <= wdata[0];
                    REG_SATA_EN: begin
                        ctrl_q.sata_en             <= wdata[0];
                        ctrl_q.sata_align_start_en <= wdata[1];
                    end
                    REG_SATA_FIFO:    ctrl_q.sata_fifo_reset <= wdata[0];
                    REG_SAMPLE_EXTRA: ctrl_q.sample_extra_en <= wdata[0];
                    default: ;
                endcase
            end
        end
    end

    always_ff @(posedge clock) begin
        if (access) begin
            rdata_q <= rdata_d;                       // Held between accesses
        end
    end

    assign cfg_rsp_o.sack  = sack_q;
    assign cfg_rsp_o.rdata = rdata_q;
    assign ctrl_o          = ctrl_q;
    assign cmd_o           = cmd_q;

endmodule

// File: daq_core.sv
// Configuration and status core of the acquisition board
// Status values arrive as inputs and control values leave as outputs
// Bus accesses are acknowledged one cycle later, with no back-pressure
// NUM_SUBSAMPLES may be 1 to 32
module daq_core #(
    parameter int NUM_SUBSAMPLES       = 32,
    parameter bit DEFAULT_SAMPLE_EXTRA = 1'b0
) (
    input  logic                                     clock,
    input  logic                                     reset,
    input  daq_pkg::cfg_req_t                        cfg_req_i,
    input  daq_pkg::daq_status_t                     status_i,
    input  daq_pkg::fifo_err_t                       fifo_err_i,
    output daq_pkg::cfg_rsp_t                        cfg_rsp_o,
    output daq_pkg::daq_ctrl_t                       ctrl_o,
    output daq_pkg::chip_cmd_t                       cmd_o,
    output logic                                     error_flag_o,
    output logic [NUM_SUBSAMPLES*daq_pkg::IDX_W-1:0] ss_chip_o,
    output logic [NUM_SUBSAMPLES*daq_pkg::IDX_W-1:0] ss_chan_o
);

    import daq_pkg::*;

    logic [4:0]       err_flags;
    err_ctrl_t        err_ctrl;
    ss_wr_t           ss_wr;
    logic [IDX_W-1:0] ss_rd_index;
    logic [IDX_W-1:0] ss_rd_chip;
    logic [IDX_W-1:0] ss_rd_chan;

    daq_cfg_regs #(
        .NUM_SUBSAMPLES      (NUM_SUBSAMPLES),
        .DEFAULT_SAMPLE_EXTRA(DEFAULT_SAMPLE_EXTRA)
    ) i_cfg_regs (
        .clock        (clock),
        .reset        (reset),
        .cfg_req_i    (cfg_req_i),
        .status_i     (status_i),
        .err_flags_i  (err_flags),
        .ss_chip_i    (ss_rd_chip),
        .ss_chan_i    (ss_rd_chan),
        .cfg_rsp_o    (cfg_rsp_o),
        .ctrl_o       (ctrl_o),
        .cmd_o        (cmd_o),
        .err_ctrl_o   (err_ctrl),
        .ss_wr_o      (ss_wr),
        .ss_rd_index_o(ss_rd_index)
    );

    subsample_table #(
        .NUM_SUBSAMPLES(NUM_SUBSAMPLES)
    ) i_subsample_table (
        .clock     (clock),
        .reset     (reset),
        .ss_wr_i   (ss_wr),
        .rd_index_i(ss_rd_index),
        .rd_chip_o (ss_rd_chip),
        .rd_chan_o (ss_rd_chan),
        .ss_chip_o (ss_chip_o),
        .ss_chan_o (ss_chan_o)
    );

    daq_error_flags i_error_flags (
        .clock       (clock),
        .reset       (reset),
        .err_ctrl_i  (err_ctrl),
        .fifo_err_i  (fifo_err_i),
        .flags_o     (err_flags),
        .error_flag_o(error_flag_o)
    );

endmodule

// File: daq_error_flags.sv
// Error flags of the DAQ core
// Bit 0 configuration, 1 UDP underflow, 2 UDP overflow,
// 3 SATA underflow, 4 SATA overflow
// FIFO pulses are only collected on cycles without a bus access
module daq_error_flags (
    input  logic               clock,
    input  logic               reset,
    input  daq_pkg::err_ctrl_t err_ctrl_i,
    input  daq_pkg::fifo_err_t fifo_err_i,
    output logic [4:0]         flags_o,
    output logic               error_flag_o
);

    import daq_pkg::*;

    logic [4:0] flags_q;
    logic [3:0] fifo_pulses;

    assign fifo_pulses = {fifo_err_i.sata_overflow, fifo_err_i.sata_underflow,
                          fifo_err_i.udp_overflow, fifo_err_i.udp_underflow};

    always_ff @(posedge clock) begin
        if (reset) begin
            flags_q <= '0;
        end else if (err_ctrl_i.load) begin
            flags_q <= err_ctrl_i.value;              // Exact value, no OR
        end else if (err_ctrl_i.set_cfg) begin
            flags_q[0] <= 1'b1;
        end else if (!err_ctrl_i.hold) begin
            flags_q[4:1] <= flags_q[4:1] | fifo_pulses;   // Sticky
        end
    end

    assign flags_o      = flags_q;
    assign error_flag_o = |flags_q;

endmodule

// File: daq_pkg.sv
// Shared widths, register map and bus types of the DAQ configuration core
// Chip and channel indexes are 5 bits, so at most 32 sub-sample slots
// Address 0x06 is left out of the map and decodes as unmapped
package daq_pkg;

    localparam int IDX_W = 5;                 // Chip or channel index width
    localparam int CFG_DATA_W = 32;
    localparam int CFG_ADDR_W = 8;
    localparam logic [CFG_ADDR_W-1:0] SUBSAMPLE_BASE = 8'h80;

    typedef enum logic [CFG_ADDR_W-1:0] {
        REG_ERRORS       = 8'h00,
        REG_ACQUIRE      = 8'h01,
        REG_DESIRED_BSN  = 8'h02,
        REG_BSN          = 8'h03,             // Read only
        REG_ALIVE        = 8'h04,             // Read only
        REG_CMD          = 8'h05,
        REG_UDP_COUNT    = 8'h07,             // Read only
        REG_UDP_FIFO     = 8'h08,
        REG_UDP_EN       = 8'h09,
        REG_UDP_MODE     = 8'h0A,
        REG_SATA_EN      = 8'h0B,
        REG_SATA_COUNT   = 8'h0C,             // Read only
        REG_SATA_FIFO    = 8'h0D,
        REG_SAMPLE_EXTRA = 8'h0E
    } cfg_addr_e;

    typedef struct packed {
        logic                  read_en;
        logic                  write_en;      // Wins over read_en
        logic [CFG_ADDR_W-1:0] addr;
        logic [CFG_DATA_W-1:0] wdata;
    } cfg_req_t;

    typedef struct packed {
        logic                  sack;
        logic [CFG_DATA_W-1:0] rdata;
    } cfg_rsp_t;

    typedef struct packed {
        logic [31:0] board_sample_index;
        logic [31:0] chips_alive;
        logic [12:0] udp_count;
        logic [14:0] sata_count;
    } daq_status_t;

    typedef struct packed {
        logic        acquire_en;
        logic        is_master;
        logic        sample_extra_en;
        logic        udp_en;
        logic        udp_full_mode;
        logic        sata_en;
        logic        sata_align_start_en;
        logic        udp_fifo_reset;
        logic        sata_fifo_reset;
        logic        reset_bsi;               // Held until the next idle cycle
        logic [31:0] desired_bsn;
    } daq_ctrl_t;

    typedef struct packed {
        logic        write_en;
        logic [7:0]  chip;
        logic [15:0] command;
    } chip_cmd_t;

    typedef struct packed {
        logic sata_overflow;
        logic sata_underflow;
        logic udp_overflow;
        logic udp_underflow;
    } fifo_err_t;

    typedef struct packed {
        logic       load;                     // Exact load of all five flags
        logic [4:0] value;
        logic       set_cfg;
        logic       hold;                     // Bus access, no accumulation
    } err_ctrl_t;

    typedef struct packed {
        logic             en;
        logic [IDX_W-1:0] index;
        logic [IDX_W-1:0] chip;
        logic [IDX_W-1:0] chan;
    } ss_wr_t;

endpackage

// File: daq_vectors.txt
# op addr data rdata err  (hex; E puts fifo_err_t pulses in data, rdata unused on E and I)
# S line: udp_count sata_count board_sample_index chips_alive
S 0abc 1def 12345678 0000000f
R 80 00000000 00000000 0
R 85 00000000 00000005 0
R 9f 00000000 0000001f 0
R 0e 00000000 00000001 0
W 83 00000a11 00000a11 0
R 83 00000000 00000a11 0
W 01 00000101 00000101 0
R 01 00000000 00000101 0
W 05 01a5beef 01a5beef 0
R 05 00000000 01a5beef 0
W 09 00000001 00000001 0
W 0a 00000001 00000001 0
W 0b 00000003 00000003 0
R 0b 00000000 00000003 0
W 0e 00000000 00000000 0
R 0e 00000000 00000000 0
W 02 cafe0001 cafe0001 0
R 02 00000000 cafe0001 0
R 03 00000000 12345678 0
R 04 00000000 0000000f 0
R 07 00000000 00000abc 0
R 0c 00000000 00001def 0
W 03 00000000 12345678 1
R 00 00000000 00000001 1
W 00 00000000 00000000 0
W 06 00000055 00000000 1
W 00 00000000 00000000 0
E 00 00000001 00000000 1
E 00 00000008 00000000 1
R 00 00000000 00000012 1
W 00 00000000 00000000 0
W 08 00000001 00000001 0
R 08 00000000 00000001 0
W 0d 00000001 00000001 0
R 0d 00000000 00000001 0
I 00 00000000 00000000 0

// File: subsample_table.sv
// Chip and channel index per sub-sample slot
// Reset loads chip 0 and channel k into slot k
// Writes beyond NUM_SUBSAMPLES are ignored, reads there return 0
module subsample_table #(
    parameter int NUM_SUBSAMPLES = 32
) (
    input  logic                                     clock,
    input  logic                                     reset,
    input  daq_pkg::ss_wr_t                          ss_wr_i,
    input  logic [daq_pkg::IDX_W-1:0]                rd_index_i,
    output logic [daq_pkg::IDX_W-1:0]                rd_chip_o,
    output logic [daq_pkg::IDX_W-1:0]                rd_chan_o,
    output logic [NUM_SUBSAMPLES*daq_pkg::IDX_W-1:0] ss_chip_o,
    output logic [NUM_SUBSAMPLES*daq_pkg::IDX_W-1:0] ss_chan_o
);

    import daq_pkg::*;

    logic [IDX_W-1:0] chip_q [NUM_SUBSAMPLES];
    logic [IDX_W-1:0] chan_q [NUM_SUBSAMPLES];
    logic             rd_valid;

    always_ff @(posedge clock) begin
        if (reset) begin
            for (int k = 0; k < NUM_SUBSAMPLES; k++) begin
                chip_q[k] <= '0;
                chan_q[k] <= IDX_W'(k);               // Identity channel map
            end
        end else if (ss_wr_i.en && (ss_wr_i.index < NUM_SUBSAMPLES)) begin
            chip_q[ss_wr_i.index] <= ss_wr_i.chip;
            chan_q[ss_wr_i.index] <= ss_wr_i.chan;
        end
    end

    assign rd_valid  = rd_index_i < NUM_SUBSAMPLES;
    assign rd_chip_o = rd_valid ? chip_q[rd_index_i] : '0;
    assign rd_chan_o = rd_valid ? chan_q[rd_index_i] : '0;

    for (genvar k = 0; k < NUM_SUBSAMPLES; k++) begin : g_pack
        assign ss_chip_o[k*IDX_W +: IDX_W] = chip_q[k];
        assign ss_chan_o[k*IDX_W +: IDX_W] = chan_q[k];
    end

endmodule

// File: tb.f
daq_pkg.sv
daq_cfg_regs.sv
subsample_table.sv
daq_error_flags.sv
daq_core.sv
tb_checker.sv
tb_daq_core.sv

// File: tb_checker.sv
// Compares DUT responses with the expectations queued by the testbench
// Responses are sampled on the falling clock edge, one cycle after the line is driven
// Holds its own model of ctrl_o, cmd_o and the sub-sample table, updated from the written fields
module tb_checker #(
    parameter int NUM_SUBSAMPLES       = 32,
    parameter bit DEFAULT_SAMPLE_EXTRA = 1'b0
) (
    input  logic                                     clock,
    input  logic                                     reset,
    input  daq_pkg::cfg_rsp_t                        cfg_rsp_i,
    input  daq_pkg::daq_ctrl_t                       ctrl_i,
    input  daq_pkg::chip_cmd_t                       cmd_i,
    input  logic                                     error_flag_i,
    input  logic [NUM_SUBSAMPLES*daq_pkg::IDX_W-1:0] ss_chip_i,
    input  logic [NUM_SUBSAMPLES*daq_pkg::IDX_W-1:0] ss_chan_i,
    output logic                                     idle_o,
    output int                                       tests_o,
    output int                                       errors_o
);

    timeunit 1ns;
    timeprecision 1ps;

    import daq_pkg::*;

    typedef struct packed {
        int          line;
        logic [7:0]  op;
        logic [7:0]  addr;
        logic [31:0] data;
        logic [31:0] rdata;
        logic        err;
    } expect_t;

    expect_t                         exp_q[$];
    expect_t                         cur;
    logic                            cur_valid;
    daq_ctrl_t                       exp_ctrl;
    chip_cmd_t                       exp_cmd;
    logic [NUM_SUBSAMPLES*IDX_W-1:0] exp_ss_chip;
    logic [NUM_SUBSAMPLES*IDX_W-1:0] exp_ss_chan;
    int                              line_errors;

    initial begin
        idle_o    = 1'b0;
        tests_o   = 0;
        errors_o  = 0;
        cur_valid = 1'b0;
    end

    task automatic push_expect(input int line, input logic [7:0] op, input logic [7:0] addr,
                               input logic [31:0] data, input logic [31:0] rdata,
                               input logic err);
        expect_t e;
        e.line  = line;
        e.op    = op;
        e.addr  = addr;
        e.data  = data;
        e.rdata = rdata;
        e.err   = err;
        exp_q.push_back(e);
    endtask

    task automatic check_value(input string name, input logic [63:0] expected,
                               input logic [63:0] actual);
        if (actual !== expected) begin
            $display("ERR %s expected 0x%0h got 0x%0h", name, expected, actual);
            line_errors++;
        end
    endtask

    // Register effects of a write, by address
    task automatic apply_write(input logic [7:0] addr, input logic [31:0] d);
        case (addr)
            REG_ACQUIRE: begin
                exp_ctrl.acquire_en = d[0];
                exp_ctrl.is_master  = d[8];
            end
            REG_DESIRED_BSN: begin
                exp_ctrl.desired_bsn = d;
                exp_ctrl.reset_bsi   = 1'b1;
            end
            REG_CMD: begin
                exp_cmd.write_en = d[24];
                exp_cmd.chip     = d[23:16];
                exp_cmd.command  = d[15:0];
            end
            REG_UDP_FIFO:     exp_ctrl.udp_fifo_reset  = d[0];
            REG_UDP_EN:       exp_ctrl.udp_en          = d[0];
            REG_UDP_MODE:     exp_ctrl.udp_full_mode   = d[0];
            REG_SATA_EN: begin
                exp_ctrl.sata_en             = d[0];
                exp_ctrl.sata_align_start_en = d[1];
            end
            REG_SATA_FIFO:    exp_ctrl.sata_fifo_reset = d[0];
            REG_SAMPLE_EXTRA: exp_ctrl.sample_extra_en = d[0];
            default: ;                                        // Read only, unmapped or table
        endcase
    endtask

    // Chip in bits 12:8, channel in bits 4:0
    task automatic write_table_model(input logic [7:0] addr, input logic [31:0] d);
        int idx;
        idx = int'(addr) - int'(SUBSAMPLE_BASE);
        if ((idx >= 0) && (idx < NUM_SUBSAMPLES)) begin
            exp_ss_chip[idx*IDX_W +: IDX_W] = d[12:8];
            exp_ss_chan[idx*IDX_W +: IDX_W] = d[4:0];
        end
    endtask

    task automatic compare_table();
        for (int k = 0; k < NUM_SUBSAMPLES; k++) begin
            check_value($sformatf("ss_chip_o[%0d]", k), exp_ss_chip[k*IDX_W +: IDX_W],
                        ss_chip_i[k*IDX_W +: IDX_W]);
            check_value($sformatf("ss_chan_o[%0d]", k), exp_ss_chan[k*IDX_W +: IDX_W],
                        ss_chan_i[k*IDX_W +: IDX_W]);
        end
    endtask

    task automatic evaluate(input expect_t e);
        logic is_access;
        is_access   = (e.op == "R") || (e.op == "W");
        line_errors = 0;
        if (is_access) begin
            if (!cfg_rsp_i.sack) begin
                $display("No acknowledge came for the access on line %0d", e.line);
                line_errors++;
            end else begin
                check_value("cfg_rsp_o.rdata", e.rdata, cfg_rsp_i.rdata);
            end
            exp_ctrl.reset_bsi = 1'b0;                        // Cleared by the idle before
            if (e.op == "W") begin
                apply_write(e.addr, e.data);
                write_table_model(e.addr, e.data);
            end
            check_value("ctrl_o", exp_ctrl, ctrl_i);
            check_value("cmd_o", exp_cmd, cmd_i);
            compare_table();
        end else if (cfg_rsp_i.sack) begin
            $display("Acknowledge seen without an access on line %0d", e.line);
            line_errors++;
        end
        check_value("error_flag_o", e.err, error_flag_i);
        tests_o++;
        if (line_errors == 0) begin
            $display("ok   line %0d %c addr 0x%h", e.line, e.op, e.addr);
        end else begin
            $display("FAIL line %0d %c addr 0x%h", e.line, e.op, e.addr);
            errors_o++;
        end
    endtask

    always @(negedge clock) begin
        if (reset) begin
            exp_ctrl                 = '0;
            exp_ctrl.sample_extra_en = DEFAULT_SAMPLE_EXTRA;
            exp_cmd                  = '0;
            for (int k = 0; k < NUM_SUBSAMPLES; k++) begin
                exp_ss_chip[k*IDX_W +: IDX_W] = '0;
                exp_ss_chan[k*IDX_W +: IDX_W] = IDX_W'(k);    // Slot k maps to channel k
            end
            cur_valid                = 1'b0;
        end else begin
            if (cur_valid) begin
                evaluate(cur);
            end
            cur_valid = 1'b0;
            if (exp_q.size() > 0) begin
                cur       = exp_q.pop_front();                // Checked on the next falling edge
                cur_valid = 1'b1;
            end
        end
        idle_o = !cur_valid && (exp_q.size() == 0);
    end

endmodule

// File: tb_daq_core.sv
// Testbench for the DAQ configuration core, driven from daq_vectors.txt
// The first vector line gives the constant status inputs
// Every access is followed by one idle cycle
module tb_daq_core;

    timeunit 1ns;
    timeprecision 1ps;

    import daq_pkg::*;

    localparam int NUM_SUBSAMPLES       = 32;
    localparam bit DEFAULT_SAMPLE_EXTRA = 1'b1;
    localparam int MAX_LINES            = 256;

    logic                            clock;
    logic                            reset;
    cfg_req_t                        cfg_req;
    daq_status_t                     status;
    fifo_err_t                       fifo_err;
    cfg_rsp_t                        cfg_rsp;
    daq_ctrl_t                       ctrl;
    chip_cmd_t                       cmd;
    logic                            error_flag;
    logic [NUM_SUBSAMPLES*IDX_W-1:0] ss_chip;
    logic [NUM_SUBSAMPLES*IDX_W-1:0] ss_chan;
    logic                            checker_idle;
    int                              tests;
    int                              errors;

    logic [7:0]  vec_op [MAX_LINES];
    logic [31:0] vec_a  [MAX_LINES];
    logic [31:0] vec_b  [MAX_LINES];
    logic [31:0] vec_c  [MAX_LINES];
    logic [31:0] vec_d  [MAX_LINES];
    int          num_lines;
    int          cycle_count;
    int          cycle_limit;
    bit          load_ok;

    daq_core #(
        .NUM_SUBSAMPLES      (NUM_SUBSAMPLES),
        .DEFAULT_SAMPLE_EXTRA(DEFAULT_SAMPLE_EXTRA)
    ) i_dut (
        .clock       (clock),
        .reset       (reset),
        .cfg_req_i   (cfg_req),
        .status_i    (status),
        .fifo_err_i  (fifo_err),
        .cfg_rsp_o   (cfg_rsp),
        .ctrl_o      (ctrl),
        .cmd_o       (cmd),
        .error_flag_o(error_flag),
        .ss_chip_o   (ss_chip),
        .ss_chan_o   (ss_chan)
    );

    tb_checker #(
        .NUM_SUBSAMPLES      (NUM_SUBSAMPLES),
        .DEFAULT_SAMPLE_EXTRA(DEFAULT_SAMPLE_EXTRA)
    ) i_checker (
        .clock       (clock),
        .reset       (reset),
        .cfg_rsp_i   (cfg_rsp),
        .ctrl_i      (ctrl),
        .cmd_i       (cmd),
        .error_flag_i(error_flag),
        .ss_chip_i   (ss_chip),
        .ss_chan_i   (ss_chan),
        .idle_o      (checker_idle),
        .tests_o     (tests),
        .errors_o    (errors)
    );

    always #20 clock = ~clock;

    always @(posedge clock) begin
        cycle_count = cycle_count + 1;
        if (cycle_count > cycle_limit) begin
            $display("Run stopped after %0d cycles without completing", cycle_count);
            $display("Verification failed");
            $finish;
        end
    end

    function automatic bit read_vectors();
        int          fd;
        int          fields;
        string       line;
        logic [7:0]  op;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] c;
        logic [31:0] d;
        fd = $fopen("daq_vectors.txt", "r");
        if (fd == 0) begin
            return 1'b0;
        end
        num_lines = 0;
        while ($fgets(line, fd) > 0) begin
            fields = $sscanf(line, "%c %h %h %h %h", op, a, b, c, d);
            if ((fields == 5) && (op != "#") && (num_lines < MAX_LINES)) begin
                vec_op[num_lines] = op;
                vec_a[num_lines]  = a;
                vec_b[num_lines]  = b;
                vec_c[num_lines]  = c;
                vec_d[num_lines]  = d;
                num_lines++;
            end
        end
        $fclose(fd);
        return (num_lines > 1) && (vec_op[0] == "S");
    endfunction

    task automatic drive(input logic rd, input logic wr, input logic [7:0] addr,
                         input logic [31:0] data, input logic [3:0] pulses);
        cfg_req_t req;
        req.read_en  = rd;
        req.write_en = wr;
        req.addr     = addr;
        req.wdata    = data;
        cfg_req  <= req;
        fifo_err <= fifo_err_t'(pulses);
    endtask

    task automatic run_vectors();
        for (int k = 1; k < num_lines; k++) begin
            @(posedge clock);
            case (vec_op[k])
                "R":     drive(1'b1, 1'b0, vec_a[k][7:0], vec_b[k], 4'h0);
                "W":     drive(1'b0, 1'b1, vec_a[k][7:0], vec_b[k], 4'h0);
                "E":     drive(1'b0, 1'b0, 8'h00, 32'h0, vec_b[k][3:0]);
                default: drive(1'b0, 1'b0, 8'h00, 32'h0, 4'h0);
            endcase
            i_checker.push_expect(k + 1, vec_op[k], vec_a[k][7:0], vec_b[k], vec_c[k],
                                  vec_d[k][0]);
            if ((vec_op[k] == "R") || (vec_op[k] == "W")) begin
                @(posedge clock);
                drive(1'b0, 1'b0, 8'h00, 32'h0, 4'h0);      // Idle after each access
            end
        end
        @(posedge clock);
        drive(1'b0, 1'b0, 8'h00, 32'h0, 4'h0);
        while (!checker_idle) begin
            @(posedge clock);
        end
    endtask

    initial begin
        clock       = 1'b0;
        reset       = 1'b1;
        cfg_req     = '0;
        status      = '0;
        fifo_err    = '0;
        cycle_count = 0;
        cycle_limit = 1000;
        load_ok     = read_vectors();
        if (!load_ok) begin
            $display("Could not read stimulus lines from daq_vectors.txt");
            $display("Verification failed");
            $finish;
        end else begin
            cycle_limit               = 4 * num_lines + 20;
            status.udp_count          = vec_a[0][12:0];
            status.sata_count         = vec_b[0][14:0];
            status.board_sample_index = vec_c[0];
            status.chips_alive        = vec_d[0];
            repeat (3) @(posedge clock);
            reset <= 1'b0;
            run_vectors();
            $display("Tests run: %0d, tests failed: %0d", tests, errors);
            if (errors == 0) begin
                $display("Verification passed");
            end else begin
                $display("Verification failed");
            end
            $finish;
        end
    end

endmodule
